/* hdl/axiLitePkg.sv */
`include "funnel_defs.svh"

package axiLitePkg;

    // Byte address on the control bus
    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;

    // Response codes used by the slave, EXOKAY and DECERR are never returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

    // Write address channel payload
    typedef struct packed {
        addr_t addr;
        logic [2:0] prot;
    } awChan_t;

    // Write data channel payload, one strobe bit per byte lane
    typedef struct packed {
        logic [31:0] data;
        logic [3:0] strb;
    } wChan_t;

    // Write response channel payload
    typedef struct packed {
        resp_t resp;
    } bChan_t;

    // Read address channel payload
    typedef struct packed {
        addr_t addr;
        logic [2:0] prot;
    } arChan_t;

    // Read data channel payload
    typedef struct packed {
        logic [31:0] data;
        resp_t resp;
    } rChan_t;

    // Register map, counter i lives at REG_COUNT_BASE plus four times i
    localparam addr_t REG_ENABLE     = 'h00;
    localparam addr_t REG_STATUS     = 'h04;
    localparam addr_t REG_CLEAR      = 'h08;
    localparam addr_t REG_COUNT_BASE = 'h10;

endpackage

/* hdl/funnelCtrl.sv */
`timescale 1ns/10ps
`include "funnel_defs.svh"

module funnelCtrl (
    input  logic                  CLK,
    input  logic                  rstN,
    input  logic                  awValid,
    output logic                  awReady,
    input  axiLitePkg::awChan_t   aw,
    input  logic                  wValid,
    output logic                  wReady,
    input  axiLitePkg::wChan_t    w,
    output logic                  bValid,
    input  logic                  bReady,
    output axiLitePkg::bChan_t    b,
    input  logic                  arValid,
    output logic                  arReady,
    input  axiLitePkg::arChan_t   ar,
    output logic                  rValid,
    input  logic                  rReady,
    output axiLitePkg::rChan_t    r,
    output logic [`FUNNEL_WIDTH-1:0] enableMask,
    output logic [`FUNNEL_WIDTH-1:0] clearMask,
    input  logic [$clog2(`QUEUE_DEPTH):0] occupancy,
    input  logic [31:0]           counts [`FUNNEL_WIDTH]
);

    logic                     wrFire;
    logic                     rdFire;
    logic [`FUNNEL_WIDTH-1:0] wrBits;
    axiLitePkg::addr_t        countOffset;
    funnelPkg::portIdx_t      countIdx;
    logic                     countHit;
    axiLitePkg::rChan_t       rdNext;

    // Handshakes complete while the registered ready pulses are high
    assign wrFire = awValid & awReady & wValid & wReady;
    assign rdFire = arValid & arReady;

    // Byte strobes select which mask bits a write may touch
    for (genvar i = 0; i < `FUNNEL_WIDTH; i++) begin : lane
        assign wrBits[i] = w.strb[i/8] & w.data[i];
    end

    // Counter window decode, only word aligned addresses inside the window hit
    assign countOffset = ar.addr - axiLitePkg::REG_COUNT_BASE;
    assign countIdx    = countOffset[2 +: $bits(funnelPkg::portIdx_t)];
    assign countHit    = ar.addr >= axiLitePkg::REG_COUNT_BASE &&
                         countOffset < axiLitePkg::addr_t'(`FUNNEL_WIDTH * 4) &&
                         ar.addr[1:0] == 2'b00;

    // Read multiplexer, the clear register is write only and answers like a hole
    always_comb begin
        rdNext = '{data: '0, resp: axiLitePkg::RESP_OKAY};
        if (ar.addr == axiLitePkg::REG_ENABLE) begin
            rdNext.data = 32'(enableMask);
        end else if (ar.addr == axiLitePkg::REG_STATUS) begin
            rdNext.data = 32'(occupancy);
        end else if (countHit) begin
            rdNext.data = counts[countIdx];
        end else begin
            rdNext.resp = axiLitePkg::RESP_SLVERR;
        end
    end

    // Write side, one transaction in flight until its response is taken
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            awReady    <= 1'b0;
            wReady     <= 1'b0;
            bValid     <= 1'b0;
            b          <= '{resp: axiLitePkg::RESP_OKAY};
            enableMask <= '1;
            clearMask  <= '0;
        end else begin
            // Address and data are accepted together in a single pulse
            awReady   <= awValid & wValid & ~bValid & ~awReady;
            wReady    <= awValid & wValid & ~bValid & ~awReady;
            clearMask <= '0;
            if (wrFire) begin
                bValid <= 1'b1;
                b.resp <= axiLitePkg::RESP_OKAY;
                if (aw.addr == axiLitePkg::REG_ENABLE) begin
                    for (int i = 0; i < `FUNNEL_WIDTH; i++) begin
                        if (w.strb[i/8]) begin
                            enableMask[i] <= w.data[i];
                        end
                    end
                end else if (aw.addr == axiLitePkg::REG_CLEAR) begin
                    // Counters named by set data bits clear on the next edge
                    clearMask <= wrBits;
                end else begin
                    // Status, counters and holes cannot be written
                    b.resp <= axiLitePkg::RESP_SLVERR;
                end
            end else if (bValid && bReady) begin
                bValid <= 1'b0;
            end
        end
    end

    // Read side, data is captured at the address handshake
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            arReady <= 1'b0;
            rValid  <= 1'b0;
            r       <= '{data: '0, resp: axiLitePkg::RESP_OKAY};
        end else begin
            arReady <= arValid & ~rValid & ~arReady;
            if (rdFire) begin
                rValid <= 1'b1;
                r      <= rdNext;
            end else if (rValid && rReady) begin
                rValid <= 1'b0;
            end
        end
    end

endmodule

/* hdl/funnelHalf.sv */
`timescale 1ns/10ps

module funnelHalf #(
    parameter int width = 2
) (
    // The clock and reset are unused here, a pipelined level would register its outputs
    input  logic             CLK,
    input  logic             rstN,
    input  logic             inValid [width],
    input  funnelPkg::item_t inItem [width],
    output logic             inReady [width],
    output logic             outValid [width/2],
    output funnelPkg::item_t outItem [width/2],
    input  logic             outReady [width/2]
);

    // Each pair of input streams collapses into one output stream
    for (genvar j = 0; j < width / 2; j++) begin : pair
        logic oddValid;

        // The odd input has priority, so it alone decides which item is passed on
        assign oddValid = inValid[2*j+1];

        // The odd input only waits on the downstream ready
        assign inReady[2*j+1] = outReady[j];

        // The even input is served only when its odd neighbour is idle
        assign inReady[2*j] = outReady[j] & ~oddValid;

        // Either input being valid makes the merged stream valid
        assign outValid[j] = oddValid | inValid[2*j];
        assign outItem[j]  = oddValid ? inItem[2*j+1] : inItem[2*j];
    end

endmodule

/* hdl/funnelPkg.sv */
`include "funnel_defs.svh"

package funnelPkg;

    // Bits needed to name a producer port
    // A single-port build still keeps one tag bit so the type is never empty
    localparam int PortBits = (`FUNNEL_WIDTH > 1) ? $clog2(`FUNNEL_WIDTH) : 1;

    // Source port number attached to every accepted item
    typedef logic [PortBits-1:0] portIdx_t;

    // Item as it travels through the tree, the queue and the output stream
    // The source tag sits above the payload in the packed word
    typedef struct packed {
        portIdx_t source;
        logic [`DATA_WIDTH-1:0] payload;
    } item_t;

endpackage

/* hdl/funnelTop.sv */
`timescale 1ns/10ps
`include "funnel_defs.svh"

module funnelTop (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   inValid [`FUNNEL_WIDTH],
    input  logic [`DATA_WIDTH-1:0] inData [`FUNNEL_WIDTH],
    output logic                   inReady [`FUNNEL_WIDTH],
    output logic                   outValid,
    output funnelPkg::item_t       outItem,
    input  logic                   outReady,
    input  logic                   awValid,
    output logic                   awReady,
    input  axiLitePkg::awChan_t    aw,
    input  logic                   wValid,
    output logic                   wReady,
    input  axiLitePkg::wChan_t     w,
    output logic                   bValid,
    input  logic                   bReady,
    output axiLitePkg::bChan_t     b,
    input  logic                   arValid,
    output logic                   arReady,
    input  axiLitePkg::arChan_t    ar,
    output logic                   rValid,
    input  logic                   rReady,
    output axiLitePkg::rChan_t     r
);

    // Merged stream between the tree and the queue
    logic             enqValid;
    funnelPkg::item_t enqItem;
    logic             enqReady;

    // Control and status between the datapath and the register block
    logic [`FUNNEL_WIDTH-1:0]      enableMask;
    logic [`FUNNEL_WIDTH-1:0]      clearMask;
    logic [`FUNNEL_WIDTH-1:0]      accept;
    logic [$clog2(`QUEUE_DEPTH):0] occupancy;
    logic [31:0]                   counts [`FUNNEL_WIDTH];

    // A port is counted in the cycle its producer handshake completes
    for (genvar i = 0; i < `FUNNEL_WIDTH; i++) begin : port
        assign accept[i] = inValid[i] & inReady[i];
    end

    funnelTree i_tree (
        .CLK(CLK), .rstN(rstN),
        .inValid(inValid), .inData(inData), .inReady(inReady), .enableMask(enableMask),
        .outValid(enqValid), .outItem(enqItem), .outReady(enqReady)
    );

    itemQueue i_queue (
        .CLK(CLK), .rstN(rstN),
        .enqValid(enqValid), .enqItem(enqItem), .enqReady(enqReady),
        .deqValid(outValid), .deqItem(outItem), .deqReady(outReady), .occupancy(occupancy)
    );

    portCounters i_counters (
        .CLK(CLK), .rstN(rstN), .accept(accept), .clearMask(clearMask), .counts(counts)
    );

    funnelCtrl i_ctrl (
        .CLK(CLK), .rstN(rstN),
        .awValid(awValid), .awReady(awReady), .aw(aw),
        .wValid(wValid), .wReady(wReady), .w(w),
        .bValid(bValid), .bReady(bReady), .b(b),
        .arValid(arValid), .arReady(arReady), .ar(ar),
        .rValid(rValid), .rReady(rReady), .r(r),
        .enableMask(enableMask), .clearMask(clearMask),
        .occupancy(occupancy), .counts(counts)
    );

endmodule

/* hdl/funnelTree.sv */
`timescale 1ns/10ps
`include "funnel_defs.svh"

module funnelTree (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   inValid [`FUNNEL_WIDTH],
    input  logic [`DATA_WIDTH-1:0] inData [`FUNNEL_WIDTH],
    output logic                   inReady [`FUNNEL_WIDTH],
    input  logic [`FUNNEL_WIDTH-1:0] enableMask,
    output logic                   outValid,
    output funnelPkg::item_t       outItem,
    input  logic                   outReady
);

    // Number of pairwise levels from the ports down to one stream
    localparam int Depth = $clog2(`FUNNEL_WIDTH);

    // Port side of the tree after masking and tagging
    logic             gatedValid [`FUNNEL_WIDTH];
    funnelPkg::item_t taggedItem [`FUNNEL_WIDTH];
    logic             treeReady [`FUNNEL_WIDTH];

    for (genvar i = 0; i < `FUNNEL_WIDTH; i++) begin : port
        // A disabled port looks idle to the tree and never sees ready
        assign gatedValid[i] = inValid[i] & enableMask[i];
        assign inReady[i]    = treeReady[i] & enableMask[i];
        // The port number goes with the payload so the consumer knows its origin
        assign taggedItem[i] = '{source: funnelPkg::portIdx_t'(i), payload: inData[i]};
    end

    if (`FUNNEL_WIDTH == 1) begin : single
        // One port needs no merging at all
        assign outValid     = gatedValid[0];
        assign outItem      = taggedItem[0];
        assign treeReady[0] = outReady;
    end else begin : tree
        for (genvar lvl = 0; lvl < Depth; lvl++) begin : level
            // Streams leaving this level, half as many as entered it
            localparam int OutW = `FUNNEL_WIDTH >> (lvl + 1);
            logic             valid [OutW];
            funnelPkg::item_t item [OutW];
            logic             ready [OutW];

            if (lvl == 0) begin : first
                funnelHalf #(.width(OutW * 2)) i_half (
                    .CLK(CLK), .rstN(rstN),
                    .inValid(gatedValid), .inItem(taggedItem), .inReady(treeReady),
                    .outValid(valid), .outItem(item), .outReady(ready)
                );
            end else begin : next
                funnelHalf #(.width(OutW * 2)) i_half (
                    .CLK(CLK), .rstN(rstN),
                    .inValid(level[lvl-1].valid), .inItem(level[lvl-1].item),
                    .inReady(level[lvl-1].ready),
                    .outValid(valid), .outItem(item), .outReady(ready)
                );
            end

            // The last level carries the single merged stream to the queue
            if (lvl == Depth - 1) begin : last
                assign outValid = valid[0];
                assign outItem  = item[0];
                assign ready[0] = outReady;
            end
        end
    end

endmodule

/* hdl/funnel_defs.svh */
`ifndef FUNNEL_DEFS_SVH
`define FUNNEL_DEFS_SVH

// Number of producer ports feeding the funnel tree
// Must be a power of two so that every tree level pairs up evenly
`define FUNNEL_WIDTH 4

// Payload width carried by every producer item
`define DATA_WIDTH 32

// Entries in the output item queue, also a power of two
// The queue pointers wrap naturally at this size
`define QUEUE_DEPTH 8

// Byte address width of the control slave
// Eight bits cover the enable, status, clear and counter registers
`define AXI_ADDR_WIDTH 8

`endif

/* hdl/itemQueue.sv */
`timescale 1ns/10ps
`include "funnel_defs.svh"

module itemQueue (
    input  logic             CLK,
    input  logic             rstN,
    input  logic             enqValid,
    input  funnelPkg::item_t enqItem,
    output logic             enqReady,
    output logic             deqValid,
    output funnelPkg::item_t deqItem,
    input  logic             deqReady,
    output logic [$clog2(`QUEUE_DEPTH):0] occupancy
);

    localparam int PtrBits = $clog2(`QUEUE_DEPTH);

    // Item storage, read directly by the output stream
    funnelPkg::item_t mem [`QUEUE_DEPTH];

    logic [PtrBits-1:0] rdPtr;
    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits:0]   count;
    logic               doEnq;
    logic               doDeq;

    // Full and empty both come straight from the entry count
    assign enqReady  = count != (PtrBits + 1)'(`QUEUE_DEPTH);
    assign deqValid  = count != '0;
    assign deqItem   = mem[rdPtr];
    assign occupancy = count;

    assign doEnq = enqValid & enqReady;
    assign doDeq = deqValid & deqReady;

    // Storage is written at the accepting edge
    always_ff @(posedge CLK) begin
        if (doEnq) begin
            mem[wrPtr] <= enqItem;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doEnq) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doDeq) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // A simultaneous push and pop leaves the count unchanged
            if (doEnq && !doDeq) begin
                count <= count + 1'b1;
            end else if (doDeq && !doEnq) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* hdl/portCounters.sv */
`timescale 1ns/10ps
`include "funnel_defs.svh"

module portCounters (
    input  logic                     CLK,
    input  logic                     rstN,
    input  logic [`FUNNEL_WIDTH-1:0] accept,
    input  logic [`FUNNEL_WIDTH-1:0] clearMask,
    output logic [31:0]              counts [`FUNNEL_WIDTH]
);

    // One counter per producer port
    for (genvar i = 0; i < `FUNNEL_WIDTH; i++) begin : port
        always_ff @(posedge CLK or negedge rstN) begin
            if (!rstN) begin
                counts[i] <= '0;
            end else if (clearMask[i]) begin
                // Software clear beats an acceptance in the same cycle
                counts[i] <= '0;
            end else if (accept[i] && counts[i] != '1) begin
                // The counter sticks at its maximum instead of wrapping
                counts[i] <= counts[i] + 1'b1;
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build the funnel testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module funnelTb -f src.f -o simv &&
    ./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim/funnelTb.sv */
`timescale 1ns/10ps
`include "funnel_defs.svh"

module funnelTb;

    localparam int Ports = `FUNNEL_WIDTH;
    localparam int TrafficCycles = 1500;
    // Two random traffic runs plus the fill, the drains and the register accesses
    localparam int StimCycles = 2 * TrafficCycles + 400;
    localparam int LimitNs = StimCycles * 20 + 2000;

    logic                   CLK = 1'b0;
    logic                   rstN;
    logic                   inValid [Ports];
    logic [`DATA_WIDTH-1:0] inData [Ports];
    logic                   inReady [Ports];
    logic                   outValid;
    funnelPkg::item_t       outItem;
    logic                   outReady;
    logic                   awValid;
    logic                   awReady;
    axiLitePkg::awChan_t    aw;
    logic                   wValid;
    logic                   wReady;
    axiLitePkg::wChan_t     w;
    logic                   bValid;
    logic                   bReady;
    axiLitePkg::bChan_t     b;
    logic                   arValid;
    logic                   arReady;
    axiLitePkg::arChan_t    ar;
    logic                   rValid;
    logic                   rReady;
    axiLitePkg::rChan_t     r;

    // Stimulus control that only ever changes at a falling edge
    integer seed = 50111;
    logic   produce = 1'b0;
    // Sink behaviour where 0 stalls, 1 is random and 2 always takes
    int     sinkMode = 0;
    logic   taken [Ports];

    // Reference model of the funnel, the queue and the counters
    logic [Ports-1:0] modelMask;
    funnelPkg::item_t expQ [$];
    int unsigned      modelCount [Ports];
    int               mismatches = 0;
    int               otherErrors = 0;
    // Handshakes the DUT actually completed on its producer ports
    int unsigned      acceptTotal = 0;

    funnelTop i_dut (
        .CLK(CLK), .rstN(rstN),
        .inValid(inValid), .inData(inData), .inReady(inReady),
        .outValid(outValid), .outItem(outItem), .outReady(outReady),
        .awValid(awValid), .awReady(awReady), .aw(aw),
        .wValid(wValid), .wReady(wReady), .w(w),
        .bValid(bValid), .bReady(bReady), .b(b),
        .arValid(arValid), .arReady(arReady), .ar(ar),
        .rValid(rValid), .rReady(rReady), .r(r)
    );

    always #5 CLK = ~CLK;

    task automatic noteFailure(input string what);
        otherErrors++;
        $display("error: %s", what);
    endtask

    task automatic checkItem(input string name, input funnelPkg::item_t expected,
                             input funnelPkg::item_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected source %0d payload %h, actual source %0d payload %h",
                     name, expected.source, expected.payload, actual.source, actual.payload);
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkResp(input string name, input axiLitePkg::resp_t expected,
                             input axiLitePkg::resp_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected %s, actual %b", name, expected.name(), actual);
        end
    endtask

    // Producers keep an item until it is taken, then draw a new one
    always @(posedge CLK) begin
        for (int i = 0; i < Ports; i++) begin
            if (!produce) begin
                inValid[i] <= 1'b0;
            end else if (!inValid[i] || taken[i]) begin
                inValid[i] <= ($random(seed) & 3) != 0;
                inData[i]  <= `DATA_WIDTH'($random(seed));
            end
        end
        if (sinkMode == 2) begin
            outReady <= 1'b1;
        end else if (sinkMode == 1) begin
            outReady <= ($random(seed) & 1) != 0;
        end else begin
            outReady <= 1'b0;
        end
    end

    // Inputs and outputs are settled at the falling edge and hold until the next rising one
    // So this sample predicts exactly the handshakes of the coming edge
    always @(negedge CLK) begin : monitor
        int               win;
        logic             full;
        logic [Ports-1:0] expAcc;
        logic [Ports-1:0] dutAcc;
        funnelPkg::item_t newItem;
        if (rstN) begin
            full = expQ.size() == `QUEUE_DEPTH;
            // Higher ports win every pair, so the highest valid enabled port is served
            win = -1;
            for (int i = 0; i < Ports; i++) begin
                if (inValid[i] && modelMask[i]) begin
                    win = i;
                end
            end
            expAcc = '0;
            if (win >= 0 && !full) begin
                expAcc[win] = 1'b1;
            end
            for (int i = 0; i < Ports; i++) begin
                dutAcc[i] = inValid[i] & inReady[i];
                taken[i]  = dutAcc[i];
            end
            acceptTotal += $countones(dutAcc);
            checkWord("accepted ports", 32'(expAcc), 32'(dutAcc));
            if (outValid !== (expQ.size() != 0)) begin
                noteFailure("output valid disagrees with the number of queued items");
            end
            if (outValid && outReady && expQ.size() != 0) begin
                checkItem("output item", expQ.pop_front(), outItem);
            end
            if (win >= 0 && !full) begin
                newItem.source  = funnelPkg::portIdx_t'(win);
                newItem.payload = inData[win];
                expQ.push_back(newItem);
                modelCount[win]++;
            end
        end
    end

    task automatic axiWrite(input axiLitePkg::addr_t addr, input logic [31:0] data,
                            output axiLitePkg::resp_t resp);
        @(posedge CLK);
        awValid <= 1'b1;
        wValid  <= 1'b1;
        aw      <= '{addr: addr, prot: 3'b000};
        w       <= '{data: data, strb: 4'hF};
        bReady  <= 1'b1;
        do @(negedge CLK); while (!(awReady && wReady));
        @(posedge CLK);
        awValid <= 1'b0;
        wValid  <= 1'b0;
        do @(negedge CLK); while (!bValid);
        resp = b.resp;
        @(posedge CLK);
        bReady <= 1'b0;
    endtask

    task automatic axiRead(input axiLitePkg::addr_t addr, output logic [31:0] data,
                           output axiLitePkg::resp_t resp);
        @(posedge CLK);
        arValid <= 1'b1;
        ar      <= '{addr: addr, prot: 3'b000};
        rReady  <= 1'b1;
        do @(negedge CLK); while (!arReady);
        @(posedge CLK);
        arValid <= 1'b0;
        do @(negedge CLK); while (!rValid);
        data = r.data;
        resp = r.resp;
        @(posedge CLK);
        rReady <= 1'b0;
    endtask

    // Counter i sits four bytes after counter i-1
    function automatic axiLitePkg::addr_t countAddr(input int port);
        return axiLitePkg::REG_COUNT_BASE + axiLitePkg::addr_t'(4 * port);
    endfunction

    task automatic checkCounters(input string name);
        logic [31:0]       data;
        axiLitePkg::resp_t resp;
        for (int i = 0; i < Ports; i++) begin
            axiRead(countAddr(i), data, resp);
            checkResp(name, axiLitePkg::RESP_OKAY, resp);
            checkWord($sformatf("%s %0d", name, i), modelCount[i], data);
        end
    endtask

    task automatic runTraffic(input int cycles, input int sink);
        @(negedge CLK);
        sinkMode = sink;
        produce  = 1'b1;
        repeat (cycles) @(negedge CLK);
        produce = 1'b0;
    endtask

    // Producers are idle here, so the model queue only shrinks
    task automatic drainQueue();
        @(negedge CLK);
        sinkMode = 2;
        while (expQ.size() != 0) @(posedge CLK);
        @(negedge CLK);
        if (outValid) begin
            noteFailure("output stream still valid after every expected item arrived");
        end
    endtask

    initial begin : main
        logic [31:0]       data;
        axiLitePkg::resp_t resp;
        logic [Ports-1:0]  newMask;
        logic [Ports-1:0]  clearBits;
        int unsigned       snapshot [Ports];
        int unsigned       startCount;
        int                total;
        rstN     = 1'b0;
        outReady = 1'b0;
        awValid  = 1'b0;
        wValid   = 1'b0;
        bReady   = 1'b0;
        arValid  = 1'b0;
        rReady   = 1'b0;
        aw       = '0;
        w        = '0;
        ar       = '0;
        for (int i = 0; i < Ports; i++) begin
            inValid[i]    = 1'b0;
            inData[i]     = '0;
            taken[i]      = 1'b0;
            modelCount[i] = 0;
        end
        modelMask = '1;
        repeat (16) @(posedge CLK);
        rstN <= 1'b1;

        // Reset values of the stream and the registers
        @(negedge CLK);
        if (outValid !== 1'b0) begin
            noteFailure("output stream valid right after reset");
        end
        axiRead(axiLitePkg::REG_ENABLE, data, resp);
        checkResp("reset enable", axiLitePkg::RESP_OKAY, resp);
        checkWord("reset enable", 32'({Ports{1'b1}}), data);
        axiRead(axiLitePkg::REG_STATUS, data, resp);
        checkWord("reset status", 32'd0, data);
        checkCounters("reset count");

        // Random traffic on every port against the priority model
        runTraffic(TrafficCycles, 1);
        drainQueue();
        checkCounters("count after traffic");

        // Fill the queue against a stalled sink, then drain it in order
        @(negedge CLK);
        startCount = acceptTotal;
        sinkMode   = 0;
        produce    = 1'b1;
        while (expQ.size() < `QUEUE_DEPTH) @(posedge CLK);
        repeat (4) begin
            @(negedge CLK);
            for (int i = 0; i < Ports; i++) begin
                if (inReady[i] !== 1'b0) begin
                    noteFailure($sformatf("port %0d ready while the queue is full", i));
                end
            end
        end
        produce = 1'b0;
        checkWord("accepted while stalled", `QUEUE_DEPTH, acceptTotal - startCount);
        axiRead(axiLitePkg::REG_STATUS, data, resp);
        checkWord("full status", `QUEUE_DEPTH, data);
        drainQueue();

        // Random mask with the top port off and port 0 on
        newMask          = `FUNNEL_WIDTH'($random(seed));
        newMask[Ports-1] = 1'b0;
        newMask[0]       = 1'b1;
        axiWrite(axiLitePkg::REG_ENABLE, 32'(newMask), resp);
        checkResp("enable write", axiLitePkg::RESP_OKAY, resp);
        modelMask = newMask;
        axiRead(axiLitePkg::REG_ENABLE, data, resp);
        checkWord("enable readback", 32'(newMask), data);
        for (int i = 0; i < Ports; i++) begin
            snapshot[i] = modelCount[i];
        end
        runTraffic(TrafficCycles, 1);
        drainQueue();
        for (int i = 0; i < Ports; i++) begin
            if (!newMask[i]) begin
                axiRead(countAddr(i), data, resp);
                checkWord($sformatf("disabled count %0d", i), snapshot[i], data);
            end
        end
        axiWrite(axiLitePkg::REG_ENABLE, 32'({Ports{1'b1}}), resp);
        modelMask = '1;

        // Counter totals and then a partial clear
        checkCounters("count after mask");
        // Port 0 is always cleared and the top port always keeps its count
        clearBits          = `FUNNEL_WIDTH'($random(seed));
        clearBits[0]       = 1'b1;
        clearBits[Ports-1] = 1'b0;
        axiWrite(axiLitePkg::REG_CLEAR, 32'(clearBits), resp);
        checkResp("clear write", axiLitePkg::RESP_OKAY, resp);
        for (int i = 0; i < Ports; i++) begin
            if (clearBits[i]) begin
                modelCount[i] = 0;
            end
        end
        checkCounters("count after clear");

        // Holes in the map answer with an error and read as zero
        axiRead(axiLitePkg::addr_t'('h0C), data, resp);
        checkResp("unmapped read", axiLitePkg::RESP_SLVERR, resp);
        checkWord("unmapped read data", 32'd0, data);
        axiRead(axiLitePkg::addr_t'('h40), data, resp);
        checkResp("unmapped read high", axiLitePkg::RESP_SLVERR, resp);
        checkWord("unmapped read high data", 32'd0, data);
        axiWrite(axiLitePkg::addr_t'('h0C), 32'hFFFF_FFFF, resp);
        checkResp("unmapped write", axiLitePkg::RESP_SLVERR, resp);

        total = mismatches + otherErrors + int'(i_dut.i_chk.failCount);
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, otherErrors, i_dut.i_chk.failCount);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(LimitNs);
        $display("Timeout: the tests did not finish within %0d ns", LimitNs);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sim/funnel_chk.sv */
`timescale 1ns/10ps
`include "funnel_defs.svh"

module funnel_chk (
    input logic             CLK,
    input logic             rstN,
    input logic             inValid [`FUNNEL_WIDTH],
    input logic             inReady [`FUNNEL_WIDTH],
    input logic             outValid,
    input funnelPkg::item_t outItem,
    input logic             outReady,
    input logic             awValid,
    input logic             awReady,
    input logic             wValid,
    input logic             wReady,
    input logic             bValid
);

    // Failure totals per property, summed for the testbench
    int unsigned          heldFails = 0;
    int unsigned          grantFails = 0;
    int unsigned          respFails = 0;
    logic [31:0]          failCount;
    logic [`FUNNEL_WIDTH-1:0] granted;

    assign failCount = heldFails + grantFails + respFails;

    always_comb begin
        for (int i = 0; i < `FUNNEL_WIDTH; i++) begin
            granted[i] = inValid[i] & inReady[i];
        end
    end

    // A stalled output item must not move or vanish
    outputHeld: assert property (@(posedge CLK) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outItem))
        else begin
            $error("output item changed while the consumer stalled");
            heldFails++;
        end

    // The tree serves one producer per cycle at most
    singleGrant: assert property (@(posedge CLK) disable iff (!rstN) $onehot0(granted))
        else begin
            $error("more than one producer accepted in one cycle");
            grantFails++;
        end

    // Every write response answers a completed address and data handshake
    respAfterWrite: assert property (@(posedge CLK) disable iff (!rstN)
        $rose(bValid) |-> $past(awValid && awReady && wValid && wReady))
        else begin
            $error("write response raised without a write handshake");
            respFails++;
        end

endmodule

bind funnelTop funnel_chk i_chk (
    .CLK(CLK), .rstN(rstN),
    .inValid(inValid), .inReady(inReady),
    .outValid(outValid), .outItem(outItem), .outReady(outReady),
    .awValid(awValid), .awReady(awReady), .wValid(wValid), .wReady(wReady),
    .bValid(bValid)
);

/* src.f */
+incdir+hdl
hdl/funnelPkg.sv
hdl/axiLitePkg.sv
hdl/funnelHalf.sv
hdl/funnelTree.sv
hdl/itemQueue.sv
hdl/portCounters.sv
hdl/funnelCtrl.sv
hdl/funnelTop.sv
sim/funnel_chk.sv
sim/funnelTb.sv
